// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/10ps -f verilog.f \
		--top-module tb_exec_top -Mdir obj_dir
	./obj_dir/Vtb_exec_top | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== include/exec_settings.svh ====
//================================================
// Widths shared by the execute slice; data width
// must stay 32 for the shift amount to fit 5 bits
//================================================

`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

`define EXEC_DATA_W  32  // Operand and result width
`define EXEC_TAG_W   4   // Command tag width
`define EXEC_SHAMT_W 5   // Shift amount taken from in1

`endif

// ==== src/exec_pkg.sv ====
//================================================
// Types for the execute slice, widths come from
// exec_settings.svh
//================================================
`default_nettype none

`include "exec_settings.svh"

package exec_pkg;

  typedef enum logic [4:0] {
    OP_ADD  = 5'd0,  OP_ADDI = 5'd1,  OP_SUB  = 5'd2,  OP_SLL  = 5'd3,
    OP_OR   = 5'd4,  OP_SLTU = 5'd5,  OP_AND  = 5'd6,  OP_XOR  = 5'd7,
    OP_NOR  = 5'd8,  OP_XNOR = 5'd9,  OP_SRL  = 5'd10, OP_SRA  = 5'd11,
    OP_MOV0 = 5'd12, OP_MOV1 = 5'd13,
    OP_BEQ  = 5'd14, OP_BNE  = 5'd15, OP_BLTZ = 5'd16, OP_BGEZ = 5'd17,
    OP_BEQZ = 5'd18
  } opcode_e;  // Codes 19 to 31 are illegal

  // Encoding follows the ALU function select
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,  ALU_SUB  = 4'd1,  ALU_SLL  = 4'd2,  ALU_OR   = 4'd3,
    ALU_LT   = 4'd4,  ALU_AND  = 4'd5,  ALU_XOR  = 4'd6,  ALU_NOR  = 4'd7,
    ALU_XNOR = 4'd8,  ALU_SRL  = 4'd9,  ALU_SRA  = 4'd10, ALU_CP0  = 4'd11,
    ALU_CP1  = 4'd12, ALU_NONE = 4'd15
  } alu_fn_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LTZ, BR_GEZ, BR_EQZ
  } br_cond_e;

  typedef struct packed {
    opcode_e                 opcode;
    logic [`EXEC_DATA_W-1:0] op0;
    logic [`EXEC_DATA_W-1:0] op1;
    logic [`EXEC_DATA_W-1:0] imm;
    logic                    use_imm;  // Take imm as second operand
    logic [`EXEC_TAG_W-1:0]  tag;
  } cmd_t;

  typedef struct packed {
    logic [`EXEC_DATA_W-1:0] in0;
    logic [`EXEC_DATA_W-1:0] in1;
    alu_fn_e                 fn;
    br_cond_e                br_cond;
    logic                    illegal;
    logic [`EXEC_TAG_W-1:0]  tag;
  } uop_t;

  typedef struct packed {
    logic [`EXEC_DATA_W-1:0] value;
    logic                    ops_eq;
    logic                    op0_zero;
    logic                    op0_neg;
    br_cond_e                br_cond;
    logic                    illegal;
    logic [`EXEC_TAG_W-1:0]  tag;
  } exe_t;

  typedef struct packed {
    logic [`EXEC_DATA_W-1:0] value;
    logic                    is_branch;
    logic                    taken;     // Zero for non-branches
    logic                    illegal;
    logic [`EXEC_TAG_W-1:0]  tag;
  } rsp_t;

endpackage

`default_nettype wire

// ==== src/exec_top.sv ====
//================================================
// Execute slice, decode to result, up to three
// commands in flight
//================================================
`timescale 1ns/10ps
`default_nettype none

module exec_top
(
  input  logic            clk,
  input  logic            rst_n,
  input  exec_pkg::cmd_t  cmd,
  input  logic            cmd_req,
  output logic            cmd_ack,
  output exec_pkg::rsp_t  rsp,
  output logic            rsp_req,
  input  logic            rsp_ack
);

  import exec_pkg::*;

  uop_t uop;
  logic uop_valid;
  logic exec_ready;
  exe_t exe;
  logic exe_valid;
  logic res_ready;

  inst_decode i_decode
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd        (cmd),
    .cmd_req    (cmd_req),
    .cmd_ack    (cmd_ack),
    .uop        (uop),
    .uop_valid  (uop_valid),
    .exec_ready (exec_ready)
  );

  exec_unit i_exec
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .uop        (uop),
    .uop_valid  (uop_valid),
    .exec_ready (exec_ready),
    .exe        (exe),
    .exe_valid  (exe_valid),
    .res_ready  (res_ready)
  );

  result_stage i_result
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .exe       (exe),
    .exe_valid (exe_valid),
    .res_ready (res_ready),
    .rsp       (rsp),
    .rsp_req   (rsp_req),
    .rsp_ack   (rsp_ack)
  );

endmodule

`default_nettype wire

// ==== src/exec_unit.sv ====
//================================================
// ALU select values 13 and 14 give zero like NONE
// Shifts use only in1[4:0]
//================================================
`timescale 1ns/10ps
`default_nettype none

`include "exec_settings.svh"

module exec_unit
(
  input  logic            clk,
  input  logic            rst_n,
  input  exec_pkg::uop_t  uop,
  input  logic            uop_valid,
  output logic            exec_ready,
  output exec_pkg::exe_t  exe,
  output logic            exe_valid,
  input  logic            res_ready
);

  import exec_pkg::*;

  logic [`EXEC_DATA_W-1:0]  alu_out;
  logic [`EXEC_SHAMT_W-1:0] shamt;
  logic                     lt_bit;
  logic                     ops_eq;
  logic                     op0_zero;
  logic                     op0_neg;
  logic                     xfer_in;

  assign shamt  = uop.in1[`EXEC_SHAMT_W-1:0];
  assign lt_bit = uop.in0 < uop.in1;           // Unsigned compare

  //================================================
  // ALU
  //================================================

  always_comb
  begin
    case (uop.fn)
      ALU_ADD  : alu_out = uop.in0 + uop.in1;
      ALU_SUB  : alu_out = uop.in0 - uop.in1;
      ALU_SLL  : alu_out = uop.in0 << shamt;
      ALU_OR   : alu_out = uop.in0 | uop.in1;
      ALU_LT   : alu_out = {{(`EXEC_DATA_W-1){1'b0}}, lt_bit};
      ALU_AND  : alu_out = uop.in0 & uop.in1;
      ALU_XOR  : alu_out = uop.in0 ^ uop.in1;
      ALU_NOR  : alu_out = ~(uop.in0 | uop.in1);
      ALU_XNOR : alu_out = ~(uop.in0 ^ uop.in1);
      ALU_SRL  : alu_out = uop.in0 >> shamt;
      ALU_SRA  : alu_out = $signed(uop.in0) >>> shamt;  // Sign fill
      ALU_CP0  : alu_out = uop.in0;
      ALU_CP1  : alu_out = uop.in1;
      default  : alu_out = '0;
    endcase
  end

  // Flags for branch resolution downstream
  assign ops_eq   = uop.in0 == uop.in1;
  assign op0_zero = uop.in0 == '0;
  assign op0_neg  = uop.in0[`EXEC_DATA_W-1];

  //================================================
  // Stage register
  //================================================

  assign exec_ready = !exe_valid || res_ready;  // Empty or transferring
  assign xfer_in    = uop_valid && exec_ready;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      exe_valid <= 1'b0;
    else if (xfer_in)
      exe_valid <= 1'b1;
    else if (res_ready)
      exe_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (xfer_in)
    begin
      exe.value    <= alu_out;
      exe.ops_eq   <= ops_eq;
      exe.op0_zero <= op0_zero;
      exe.op0_neg  <= op0_neg;
      exe.br_cond  <= uop.br_cond;
      exe.illegal  <= uop.illegal;
      exe.tag      <= uop.tag;
    end
  end

endmodule

`default_nettype wire

// ==== src/inst_decode.sv ====
//================================================
// Command side is four-phase; cmd must hold while
// cmd_req is high. Illegal opcodes decode to NONE
//================================================
`timescale 1ns/10ps
`default_nettype none

module inst_decode
(
  input  logic            clk,
  input  logic            rst_n,
  input  exec_pkg::cmd_t  cmd,
  input  logic            cmd_req,
  output logic            cmd_ack,
  output exec_pkg::uop_t  uop,
  output logic            uop_valid,
  input  logic            exec_ready
);

  import exec_pkg::*;

  uop_t uop_d;
  logic load_en;
  logic capture;

  assign load_en = !uop_valid || exec_ready;       // Empty or draining
  assign capture = cmd_req && !cmd_ack && load_en;

  //================================================
  // Opcode decode
  //================================================

  always_comb
  begin
    uop_d.in0     = cmd.op0;
    uop_d.in1     = (cmd.use_imm || cmd.opcode == OP_ADDI) ? cmd.imm : cmd.op1;
    uop_d.fn      = ALU_NONE;
    uop_d.br_cond = BR_NONE;
    uop_d.illegal = 1'b0;
    uop_d.tag     = cmd.tag;

    case (cmd.opcode)
      OP_ADD,
      OP_ADDI : uop_d.fn = ALU_ADD;
      OP_SUB  : uop_d.fn = ALU_SUB;
      OP_SLL  : uop_d.fn = ALU_SLL;
      OP_OR   : uop_d.fn = ALU_OR;
      OP_SLTU : uop_d.fn = ALU_LT;
      OP_AND  : uop_d.fn = ALU_AND;
      OP_XOR  : uop_d.fn = ALU_XOR;
      OP_NOR  : uop_d.fn = ALU_NOR;
      OP_XNOR : uop_d.fn = ALU_XNOR;
      OP_SRL  : uop_d.fn = ALU_SRL;
      OP_SRA  : uop_d.fn = ALU_SRA;
      OP_MOV0 : uop_d.fn = ALU_CP0;
      OP_MOV1 : uop_d.fn = ALU_CP1;
      OP_BEQ  : uop_d.br_cond = BR_EQ;   // Branches keep fn NONE
      OP_BNE  : uop_d.br_cond = BR_NE;
      OP_BLTZ : uop_d.br_cond = BR_LTZ;
      OP_BGEZ : uop_d.br_cond = BR_GEZ;
      OP_BEQZ : uop_d.br_cond = BR_EQZ;
      default : uop_d.illegal = 1'b1;
    endcase
  end

  //================================================
  // Handshake and stage register
  //================================================

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      cmd_ack   <= 1'b0;
      uop_valid <= 1'b0;
    end
    else
    begin
      if (capture)
        cmd_ack <= 1'b1;
      else if (cmd_ack && !cmd_req)
        cmd_ack <= 1'b0;                  // Return to idle phase

      if (capture)
        uop_valid <= 1'b1;
      else if (exec_ready)
        uop_valid <= 1'b0;                // Item moved on
    end
  end

  always_ff @(posedge clk)
  begin
    if (capture)
      uop <= uop_d;
  end

endmodule

`default_nettype wire

// ==== src/result_stage.sv ====
//================================================
// One-entry response buffer, four-phase on the
// output; new rsp_req waits for rsp_ack low
//================================================
`timescale 1ns/10ps
`default_nettype none

module result_stage
(
  input  logic            clk,
  input  logic            rst_n,
  input  exec_pkg::exe_t  exe,
  input  logic            exe_valid,
  output logic            res_ready,
  output exec_pkg::rsp_t  rsp,
  output logic            rsp_req,
  input  logic            rsp_ack
);

  import exec_pkg::*;

  logic rsp_full;
  logic taken;
  logic load_en;

  //================================================
  // Branch resolution
  //================================================

  always_comb
  begin
    case (exe.br_cond)
      BR_EQ   : taken = exe.ops_eq;
      BR_NE   : taken = !exe.ops_eq;
      BR_LTZ  : taken = exe.op0_neg;
      BR_GEZ  : taken = !exe.op0_neg;
      BR_EQZ  : taken = exe.op0_zero;
      default : taken = 1'b0;
    endcase
  end

  //================================================
  // Response buffer and handshake
  //================================================

  assign res_ready = !rsp_full;
  assign load_en   = exe_valid && res_ready;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      rsp_full <= 1'b0;
      rsp_req  <= 1'b0;
    end
    else if (rsp_req && rsp_ack)
    begin
      rsp_full <= 1'b0;                 // Consumer took it
      rsp_req  <= 1'b0;
    end
    else if (load_en)
    begin
      rsp_full <= 1'b1;
      rsp_req  <= !rsp_ack;             // Hold off while old ack high
    end
    else if (rsp_full && !rsp_req && !rsp_ack)
      rsp_req  <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (load_en)
    begin
      rsp.value     <= exe.value;
      rsp.is_branch <= exe.br_cond != BR_NONE;
      rsp.taken     <= taken;
      rsp.illegal   <= exe.illegal;
      rsp.tag       <= exe.tag;
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_exec_top.sv ====
//================================================
// Inputs driven 0.5 ns after the rising edge
// Run stops at the first mismatch or on timeout
//================================================
`timescale 1ns/10ps
`default_nettype none

`include "exec_settings.svh"

module tb_exec_top;

  import exec_pkg::*;

  localparam int N_CMDS         = 400;
  localparam int STALL_START    = 200;          // Slow consumer from here
  localparam int FAST_START     = 300;          // Back-to-back from here
  localparam int TIMEOUT_CYCLES = N_CMDS * 20;

  logic clk;
  logic rst_n;
  cmd_t cmd;
  logic cmd_req;
  logic cmd_ack;
  rsp_t rsp;
  logic rsp_req;
  logic rsp_ack;

  cmd_t cmd_list [$];
  rsp_t exp_q [$];                              // Expected responses, oldest first
  int   rsp_count   = 0;
  int   cycle_count = 0;

  exec_top i_dut
  (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd     (cmd),
    .cmd_req (cmd_req),
    .cmd_ack (cmd_ack),
    .rsp     (rsp),
    .rsp_req (rsp_req),
    .rsp_ack (rsp_ack)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
      abort_run($sformatf("Timeout after %0d cycles with %0d of %0d responses received",
                          cycle_count, rsp_count, N_CMDS));
  end

  //================================================
  // Helpers and reference model
  //================================================

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic wait_cycle();
    @(posedge clk);
    #0.5;                                       // Past the edge, outputs settled
  endtask

  function automatic rsp_t ref_rsp(input cmd_t c);
    rsp_t                    r;
    logic [`EXEC_DATA_W-1:0] a;
    logic [`EXEC_DATA_W-1:0] b;
    logic [4:0]              sh;
    a       = c.op0;
    b       = (c.use_imm || c.opcode == OP_ADDI) ? c.imm : c.op1;
    sh      = b[4:0];
    r       = '0;
    r.tag   = c.tag;
    case (c.opcode)
      OP_ADD, OP_ADDI : r.value = a + b;
      OP_SUB  : r.value = a - b;
      OP_SLL  : r.value = a << sh;
      OP_OR   : r.value = a | b;
      OP_SLTU : r.value[0] = a < b;
      OP_AND  : r.value = a & b;
      OP_XOR  : r.value = a ^ b;
      OP_NOR  : r.value = ~(a | b);
      OP_XNOR : r.value = ~(a ^ b);
      OP_SRL  : r.value = a >> sh;
      OP_SRA  : r.value = (a >> sh) | (a[31] ? ~({`EXEC_DATA_W{1'b1}} >> sh) : '0);
      OP_MOV0 : r.value = a;
      OP_MOV1 : r.value = b;
      OP_BEQ  : {r.is_branch, r.taken} = {1'b1, a == b};
      OP_BNE  : {r.is_branch, r.taken} = {1'b1, a != b};
      OP_BLTZ : {r.is_branch, r.taken} = {1'b1, a[31]};
      OP_BGEZ : {r.is_branch, r.taken} = {1'b1, !a[31]};
      OP_BEQZ : {r.is_branch, r.taken} = {1'b1, a == '0};
      default : r.illegal = 1'b1;               // Value stays zero
    endcase
    return r;
  endfunction

  task automatic check_alu_rsp(input rsp_t got, input rsp_t exp);
    if (got.tag != exp.tag)
      abort_run($sformatf("Fail rsp.tag: got 0x%0h, expected 0x%0h", got.tag, exp.tag));
    else if (got.value != exp.value)
      abort_run($sformatf("Fail rsp.value (tag 0x%0h): got 0x%08h, expected 0x%08h",
                          exp.tag, got.value, exp.value));
    else if (got.illegal != exp.illegal)
      abort_run($sformatf("Fail rsp.illegal (tag 0x%0h): got 0x%0h, expected 0x%0h",
                          exp.tag, got.illegal, exp.illegal));
  endtask

  task automatic check_branch_rsp(input rsp_t got, input rsp_t exp);
    if (got.tag != exp.tag)
      abort_run($sformatf("Fail rsp.tag: got 0x%0h, expected 0x%0h", got.tag, exp.tag));
    else if (got.is_branch != exp.is_branch)
      abort_run($sformatf("Fail rsp.is_branch (tag 0x%0h): got 0x%0h, expected 0x%0h",
                          exp.tag, got.is_branch, exp.is_branch));
    else if (got.taken != exp.taken)
      abort_run($sformatf("Fail rsp.taken (tag 0x%0h): got 0x%0h, expected 0x%0h",
                          exp.tag, got.taken, exp.taken));
  endtask

  task automatic add_cmd(input opcode_e op, input logic [`EXEC_DATA_W-1:0] a,
                         input logic [`EXEC_DATA_W-1:0] b,
                         input logic [`EXEC_DATA_W-1:0] imm, input logic use_imm);
    cmd_t c;
    c.opcode  = op;
    c.op0     = a;
    c.op1     = b;
    c.imm     = imm;
    c.use_imm = use_imm;
    c.tag     = `EXEC_TAG_W'(cmd_list.size());  // Wraps, still shows order
    cmd_list.push_back(c);
  endtask

  //================================================
  // Command list
  //================================================

  task automatic build_cmd_list();
    opcode_e                 alu_ops [0:12] = '{OP_ADD, OP_SUB, OP_SLL, OP_OR, OP_SLTU,
                                                OP_AND, OP_XOR, OP_NOR, OP_XNOR, OP_SRL,
                                                OP_SRA, OP_MOV0, OP_MOV1};
    opcode_e                 br_ops [0:4]   = '{OP_BEQ, OP_BNE, OP_BLTZ, OP_BGEZ, OP_BEQZ};
    logic [`EXEC_DATA_W-1:0] ea [0:6] = '{32'h0, 32'hffffffff, 32'h80000000, 32'hffffffff,
                                          32'h80000000, 32'h7fffffff, 32'h00000001};
    logic [`EXEC_DATA_W-1:0] eb [0:6] = '{32'h0, 32'h00000001, 32'h0000001f, 32'hffffffff,
                                          32'h80000000, 32'h80000000, 32'h0000001f};
    logic [`EXEC_DATA_W-1:0] a;
    opcode_e                 op;
    foreach (alu_ops[i])
      foreach (ea[j])
        add_cmd(alu_ops[i], ea[j], eb[j], 32'h12345678, 1'b0);
    add_cmd(OP_ADDI, 32'h00000100, 32'hdeadbeef, 32'h00000010, 1'b0);
    add_cmd(OP_ADDI, 32'h00000005, 32'h0, 32'hffffffff, 1'b0);  // imm of minus one
    add_cmd(OP_SUB, 32'h00000050, 32'h0, 32'h00000051, 1'b1);
    add_cmd(OP_SLL, 32'h00000001, 32'h0, 32'h0000001f, 1'b1);
    add_cmd(OP_MOV1, 32'h0, 32'hcafef00d, 32'h0badf00d, 1'b1);
    add_cmd(OP_BEQ, 32'h00000077, 32'h0, 32'h00000077, 1'b1);
    foreach (br_ops[i])
      foreach (ea[j])
        add_cmd(br_ops[i], ea[j], eb[j], 32'h0, 1'b0);         // Equal, zero and negative pairs
    for (int k = 19; k < 32; k++)
      add_cmd(opcode_e'(5'(k)), 32'h11111111, 32'h22222222, 32'h0, 1'b0);
    while (cmd_list.size() < N_CMDS)
    begin
      op = opcode_e'(5'($urandom_range(0, 20)));              // 19 and 20 illegal
      a  = ($urandom_range(0, 7) == 0) ? '0 : $urandom();
      add_cmd(op, a, ($urandom_range(0, 3) == 0) ? a : $urandom(), $urandom(),
              1'($urandom_range(0, 1)));
    end
  endtask

  //================================================
  // Producer, consumer and main sequence
  //================================================

  task automatic send_cmd(input cmd_t c, input int idx);
    int gap;
    gap = (idx >= FAST_START) ? 0 : int'($urandom_range(0, 3));
    repeat (gap) wait_cycle();
    cmd     = c;
    cmd_req = 1'b1;
    exp_q.push_back(ref_rsp(c));
    wait_cycle();
    while (!cmd_ack) wait_cycle();
    cmd_req = 1'b0;
    while (cmd_ack) wait_cycle();
  endtask

  function automatic int ack_delay(input int idx);
    if (idx >= FAST_START)
      return 0;
    if (idx >= STALL_START)
      return (idx % 10 == 0) ? 40 : int'($urandom_range(0, 12));  // Long holds
    return int'($urandom_range(0, 5));
  endfunction

  initial
  begin : consumer
    rsp_t got;
    rsp_t exp;
    @(posedge rst_n);
    forever
    begin
      wait_cycle();
      if (rsp_req && exp_q.size() == 0)
        abort_run("Response offered with no command outstanding");
      else if (rsp_req)
      begin
        got = rsp;
        exp = exp_q.pop_front();
        check_alu_rsp(got, exp);
        check_branch_rsp(got, exp);
        repeat (ack_delay(rsp_count)) wait_cycle();
        rsp_ack = 1'b1;
        while (rsp_req) wait_cycle();
        rsp_ack = 1'b0;
        rsp_count++;
      end
    end
  end

  initial
  begin : main
    void'($urandom(60166));
    rst_n   = 1'b0;
    cmd     = '0;
    cmd_req = 1'b0;
    rsp_ack = 1'b0;
    build_cmd_list();
    repeat (5) wait_cycle();
    rst_n = 1'b1;
    wait_cycle();
    if (cmd_ack !== 1'b0)
      abort_run($sformatf("Fail cmd_ack after reset: got 0x%0h, expected 0x0", cmd_ack));
    if (rsp_req !== 1'b0)
      abort_run($sformatf("Fail rsp_req after reset: got 0x%0h, expected 0x0", rsp_req));
    foreach (cmd_list[i])
      send_cmd(cmd_list[i], i);
    while (rsp_count < N_CMDS) wait_cycle();
    repeat (6) wait_cycle();                    // Catch any stray response
    if (!rsp_req)
    begin
      $display("All tests passed!");
      $finish;
    end
    else
      abort_run("Extra response offered after the last command");
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
src/exec_pkg.sv
src/inst_decode.sv
src/exec_unit.sv
src/result_stage.sv
src/exec_top.sv
test/tb_exec_top.sv
